// ==== execute_alu.f ====
logic/rv_isa_pkg.sv
logic/alu_cfg_pkg.sv
logic/alu_decoder.sv
logic/barrel_shifter.sv
logic/approx_adder.sv
logic/execute_alu.sv
bench/execute_alu_tb.sv

// ==== Bender.yml ====
package:
  name: execute_alu

sources:
  # Packages first, the request struct uses the ISA enums
  - logic/rv_isa_pkg.sv
  - logic/alu_cfg_pkg.sv
  - logic/alu_decoder.sv
  - logic/barrel_shifter.sv
  - logic/approx_adder.sv
  - logic/execute_alu.sv

  - target: test
    files:
      - bench/execute_alu_tb.sv

// ==== bench/execute_alu_tb.sv ====
// --------------------------------------
// Testbench for the execute-stage ALU
// LFSR stimulus, reference model, compare process,
// watchdog
// --------------------------------------
`timescale 1ns/10ps

module execute_alu_tb;
    import rv_isa_pkg::*;
    import alu_cfg_pkg::*;

    localparam int N_EXACT = 19 * 12;   // Every supported instruction, 12 times
    localparam int N_ADD   = 120;
    localparam int N_SUB   = 100;
    localparam int N_ILL   = 60;
    localparam int N_BURST = 40;
    localparam int N_TOTAL = N_EXACT + N_ADD + N_SUB + N_ILL + N_BURST;

    logic      clk;
    logic      arst_n;
    logic      req_valid;
    alu_req_t  req;
    apx_ctrl_t apx_ctrl;
    logic      rsp_valid;
    alu_rsp_t  rsp;

    logic        exp_valid = 1'b0;      // Strobe seen at the last rising edge
    logic [31:0] lfsr      = 32'h5048;
    alu_rsp_t    exp_q[$];              // Expected responses, oldest first
    string       name_q[$];
    int          n_tests;
    int          n_checks;
    int          n_errs;

    execute_alu u_execute_alu
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .apx_ctrl  (apx_ctrl),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #10 clk = ~clk;  // 20 ns period

    // Galois LFSR, one step per bit taken
    function automatic word_t next_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[XLEN-2:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // --------------------------------------
    // Reference model
    // --------------------------------------
    // Approximate carry-select rule, bit by bit
    function automatic word_t approx_add(input word_t a, input word_t b, input logic cin,
                                         input logic [APX_LEN-1:0] en);
        word_t              s;
        logic [BLOCK_W-1:0] bs;     // Block sum before select
        logic               c;
        logic               bc;     // Carry between blocks
        logic               e;
        int                 i;
        bc = 1'b0;
        for (int k = 0; k < XLEN / BLOCK_W; k++)
        begin
            c = (k == 0) ? cin : 1'b0;  // Zero carry makes the low cell a half adder
            for (int j = 0; j < BLOCK_W; j++)
            begin
                i     = k * BLOCK_W + j;
                e     = (i >= APX_LEN) || en[i];
                bs[j] = e ? a[i] ^ b[i] ^ c : (a[i] ^ b[i]) | c;
                c     = e ? (a[i] & b[i]) | ((a[i] ^ b[i]) & c) : (b[i] | c) & a[i];
            end
            s[k*BLOCK_W +: BLOCK_W] = (k != 0 && bc) ? bs + 1'b1 : bs;
            bc = (k != 0 && bc) ? c | (&bs) : c;   // Increment may wrap
        end
        return s;
    endfunction

    // Expected response from the RV32 rules
    function automatic alu_rsp_t expected_rsp(input alu_req_t r, input apx_ctrl_t c);
        alu_rsp_t e;
        word_t    b;
        logic     alt;
        logic     exact;
        logic     sub;
        b     = (r.opcode == OPC_OP_IMM) ? r.immediate : r.rs2;
        alt   = (r.funct7 == F7_ALT);
        exact = !c.approximate || (&c.error_control[APX_LEN-1:0]);
        sub   = (r.opcode == OPC_OP) && alt;
        if (r.opcode == OPC_OP)
            e.illegal = !(r.funct7 == F7_BASE || (alt && r.funct3 inside {F3_ADD, F3_SR}));
        else if (r.opcode == OPC_OP_IMM)
            e.illegal = (r.funct3 == F3_SLL && r.funct7 != F7_BASE)
                || (r.funct3 == F3_SR && r.funct7 != F7_BASE && !alt);
        else
            e.illegal = 1'b1;
        case (r.funct3)
            F3_ADD:
                if (exact)
                    e.result = sub ? r.rs1 - b : r.rs1 + b;
                else
                    e.result = approx_add(r.rs1, sub ? ~b : b, sub, c.error_control[APX_LEN-1:0]);
            F3_SLL  : e.result = r.rs1 << b[4:0];
            F3_SLT  : e.result = {31'b0, $signed(r.rs1) < $signed(b)};
            F3_SLTU : e.result = {31'b0, r.rs1 < b};
            F3_XOR  : e.result = r.rs1 ^ b;
            F3_SR   : e.result = word_t'({{XLEN{alt & r.rs1[XLEN-1]}}, r.rs1} >> b[4:0]);
            F3_OR   : e.result = r.rs1 | b;
            default : e.result = r.rs1 & b;
        endcase
        if (e.illegal)
            e.result = '0;
        return e;
    endfunction

    // --------------------------------------
    // Stimulus and checks
    // --------------------------------------
    // Request n of a test; idx 0-9 are OP forms, 10-18 OP_IMM forms
    task automatic make_stim(input int kind, input int n, output alu_req_t r,
                             output apx_ctrl_t c);
        int         idx;
        logic [1:0] sel;
        word_t      imm;
        imm           = next_bits(12);
        r.rs1         = next_bits(XLEN);
        r.rs2         = next_bits(XLEN);
        r.immediate   = {{20{imm[11]}}, imm[11:0]};    // I-type sign extension
        c             = next_bits(XLEN);
        c.approximate = (kind != 0);
        if (kind == 1 && n >= N_ADD - 20)
            c.error_control[APX_LEN-1:0] = '1;          // All cells exact
        case (kind)
            0       : idx = n % 19;
            1       : idx = next_bits(1) ? 10 : 0;      // ADDI or ADD
            2       : idx = 8;                          // SUB
            default : idx = next_bits(5) % 19;
        endcase
        r.opcode = (idx < 10) ? OPC_OP : OPC_OP_IMM;
        case (idx)
            8       : r.funct3 = F3_ADD;
            9, 18   : r.funct3 = F3_SR;
            default : r.funct3 = funct3_e'(3'(idx % 10));
        endcase
        if (idx inside {8, 9, 18})
            r.funct7 = F7_ALT;
        else if (idx < 10 || r.funct3 inside {F3_SLL, F3_SR})
            r.funct7 = F7_BASE;
        else
            r.funct7 = 7'(next_bits(7));    // Don't care for these immediates
        if (kind == 3)
        begin
            sel      = 2'(next_bits(2));
            r.opcode = (sel == 1) ? OPC_OP_IMM : OPC_OP;
            r.funct7 = (sel == 0) ? 7'(next_bits(7)) | 7'h01 : F7_ALT;
            if (sel == 1)
                r.funct3 = F3_SLL;                              // SLLI with F7_ALT
            else if (sel == 2)
                r.funct3 = funct3_e'(3'(next_bits(2)) + 3'd1);  // SLL to XOR, F7_ALT
            else if (sel == 3)
                r.opcode = opcode_e'(7'(next_bits(7)) | 7'h04); // Neither OP nor OP_IMM
        end
    endtask

    task automatic check_rsp(input string name, input alu_rsp_t exp, input alu_rsp_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errs++;
            $display("Fail %s: expected result %h illegal %b, actual result %h illegal %b",
                     name, exp.result, exp.illegal, act.result, act.illegal);
        end
    endtask

    task automatic check_idle(input string name, input logic act);
        n_checks++;
        if (act !== 1'b0)
        begin
            n_errs++;
            $display("Fail %s: expected rsp_valid 0, actual %b", name, act);
        end
    endtask

    // Called on a falling edge; burst kind sends back to back
    task automatic run_test(input string name, input int kind, input int count);
        alu_req_t  r;
        apx_ctrl_t c;
        alu_rsp_t  e;
        int        errs_at_start;
        errs_at_start = n_errs;
        for (int n = 0; n < count; n++)
        begin
            make_stim(kind, n, r, c);
            e = expected_rsp(r, c);
            req_valid = 1'b1;
            req       = r;
            apx_ctrl  = c;
            exp_q.push_back(e);
            name_q.push_back(name);
            @(negedge clk);
            req_valid = 1'b0;
            // SUB error band on the registered result, low byte plus carry into bit 8
            if (kind == 2 && (rsp.result - (r.rs1 - r.rs2) + 32'd511) > 32'd1022)
            begin
                n_errs++;
                $display("ERROR %s: SUB result strays above bit 8", name);
            end
            if (kind != 4 && next_bits(1))
                @(negedge clk);     // Idle gap
        end
        if (kind == 4)
            repeat (6) @(negedge clk);
        while (exp_q.size() != 0)
            @(negedge clk);
        n_tests++;
        $display("Test %s: %0d requests, %0d errors", name, count, n_errs - errs_at_start);
    endtask

    // --------------------------------------
    // Compare process
    // --------------------------------------
    always @(posedge clk)
        exp_valid <= req_valid;

    always @(negedge clk)
    begin
        if (arst_n && exp_valid)
        begin
            if (!rsp_valid)
            begin
                n_errs++;
                $display("ERROR %s: no response one cycle after the strobe", name_q[0]);
            end
            check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
        end
        else if (arst_n)
            check_idle("idle gap", rsp_valid);     // No response without a strobe
    end

    // Watchdog, two cycles per request plus margin
    initial
    begin
        #(N_TOTAL * 40 + 1000);
        $display("ERROR: watchdog expired before all responses arrived");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        apx_ctrl  = '0;
        repeat (2) @(negedge clk);
        check_idle("reset", rsp_valid);
        check_rsp("reset", '0, rsp);
        arst_n = 1'b1;
        run_test("exact_ops", 0, N_EXACT);
        run_test("approx_add", 1, N_ADD);
        run_test("approx_sub", 2, N_SUB);
        run_test("illegal", 3, N_ILL);
        run_test("burst", 4, N_BURST);
        $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errs);
        if (n_errs == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== logic/execute_alu.sv ====
// --------------------------------------
// Execute-stage integer ALU, one-cycle stage
// Operand select, SUB prep, result mux, output register
// --------------------------------------
`timescale 1ns/10ps

module execute_alu
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,  // Single-cycle strobe
    input  alu_cfg_pkg::alu_req_t  req,
    input  alu_cfg_pkg::apx_ctrl_t apx_ctrl,
    output logic                   rsp_valid,
    output alu_cfg_pkg::alu_rsp_t  rsp
);
    import rv_isa_pkg::*;
    import alu_cfg_pkg::*;

    alu_op_e            alu_op;
    logic               use_imm;
    logic               illegal;
    word_t              op_b;       // rs2 or immediate
    word_t              add_b;      // Inverted for SUB
    logic               add_cin;
    logic [APX_LEN-1:0] error_en;
    word_t              add_sum;
    word_t              shift_res;
    alu_rsp_t           rsp_d;

    alu_decoder u_alu_decoder
    (
        .req     (req),
        .alu_op  (alu_op),
        .use_imm (use_imm),
        .illegal (illegal)
    );

    // --------------------------------------
    // Operands and adder control
    // --------------------------------------
    assign op_b    = use_imm ? req.immediate : req.rs2;
    assign add_cin = (alu_op == ALU_SUB);  // rs1 + ~op_b + 1
    assign add_b   = add_cin ? ~op_b : op_b;
    // Exact mode forces every cell enable high
    assign error_en = apx_ctrl.error_control[APX_LEN-1:0] | {APX_LEN{~apx_ctrl.approximate}};

    approx_adder #(.APX_LEN(APX_LEN)) u_approx_adder
    (
        .error_en (error_en),
        .a        (req.rs1),
        .b        (add_b),
        .cin      (add_cin),
        .sum      (add_sum)
    );

    barrel_shifter #(.WIDTH(XLEN)) u_barrel_shifter
    (
        .value       (req.rs1),
        .shamt       (op_b[SHAMT_W-1:0]),  // Low bits of rs2 or imm
        .shift_right (alu_op inside {ALU_SRL, ALU_SRA}),
        .arith       (alu_op == ALU_SRA),
        .result      (shift_res)
    );

    // --------------------------------------
    // Result select
    // --------------------------------------
    always_comb
    begin
        rsp_d.illegal = illegal;
        case (alu_op)
            ALU_ADD, ALU_SUB         : rsp_d.result = add_sum;
            ALU_SLL, ALU_SRL, ALU_SRA: rsp_d.result = shift_res;
            ALU_SLT  : rsp_d.result = word_t'($signed(req.rs1) < $signed(op_b));
            ALU_SLTU : rsp_d.result = word_t'(req.rs1 < op_b);
            ALU_XOR  : rsp_d.result = req.rs1 ^ op_b;
            ALU_OR   : rsp_d.result = req.rs1 | op_b;
            ALU_AND  : rsp_d.result = req.rs1 & op_b;
            default  : rsp_d.result = '0;  // Illegal gives zero
        endcase
    end

    // Output stage, rsp held until the next strobe
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end
        else
        begin
            rsp_valid <= req_valid;
            if (req_valid)
                rsp <= rsp_d;
        end
    end

    // Exact mode SUB is plain two's complement subtraction
    a_exact_sub: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !apx_ctrl.approximate && alu_op == ALU_SUB
        |=> rsp.result == $past(req.rs1 - op_b));
    a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && rsp.illegal |-> rsp.result == '0);

endmodule

// ==== logic/approx_adder.sv ====
// --------------------------------------
// Error-configurable carry-select adder
// Approximate ripple cells in the low APX_LEN bits,
// 4-bit blocks with increment unit and block mux above
// --------------------------------------
`timescale 1ns/10ps

module approx_adder
#(
    parameter int APX_LEN = alu_cfg_pkg::APX_LEN
)
(
    input  logic [APX_LEN-1:0] error_en,   // 1 = exact cell
    input  alu_cfg_pkg::word_t a,
    input  alu_cfg_pkg::word_t b,
    input  logic               cin,
    output alu_cfg_pkg::word_t sum
);
    import alu_cfg_pkg::*;

    localparam int NBLK = XLEN / BLOCK_W;

    word_t            raw_sum;  // Block sums before carry select
    logic [XLEN:1]    rc;       // Carry out of each bit inside its block
    logic [NBLK-1:0]  blk_c;    // Selected carry out of each block

    if (APX_LEN % BLOCK_W != 0 || APX_LEN < BLOCK_W)
    begin : g_bad_len
        $error("APX_LEN must be a nonzero multiple of BLOCK_W");
    end

    // --------------------------------------
    // Bit cells
    // --------------------------------------
    for (genvar i = 0; i < XLEN; i++)
    begin : g_cell
        if (i != 0 && i % BLOCK_W == 0)
        begin : g_ha
            assign raw_sum[i] = a[i] ^ b[i];    // Block starts with a half adder
            assign rc[i+1]    = a[i] & b[i];
        end
        else
        begin : g_fa
            logic c_in;
            logic en;
            logic p;

            if (i == 0)
            begin : g_first
                assign c_in = cin;
            end
            else
            begin : g_chain
                assign c_in = rc[i];
            end

            if (i < APX_LEN)
            begin : g_apx
                assign en = error_en[i];
            end
            else
            begin : g_exact
                assign en = 1'b1;   // Exact above APX_LEN
            end

            assign p = a[i] ^ b[i];

            // Exact when en set, else OR sum and relaxed carry
            assign raw_sum[i] = ~(en & p & c_in) & (p | c_in);
            assign rc[i+1]    = (en & b[i] & c_in) | ((b[i] | c_in) & a[i]);
        end
    end

    // --------------------------------------
    // Carry select per block
    // --------------------------------------
    assign sum[BLOCK_W-1:0] = raw_sum[BLOCK_W-1:0];    // Low block ripples from cin
    assign blk_c[0]         = rc[BLOCK_W];

    for (genvar k = 1; k < NBLK; k++)
    begin : g_blk
        localparam int BASE = k * BLOCK_W;

        logic [BLOCK_W-1:0] inc;    // Block sum plus one
        logic               ovf;    // Increment wraps

        assign inc = raw_sum[BASE +: BLOCK_W] + BLOCK_W'(1);
        assign ovf = &raw_sum[BASE +: BLOCK_W];

        always_comb
        begin
            if (blk_c[k-1])
            begin
                sum[BASE +: BLOCK_W] = inc;
                blk_c[k]             = rc[BASE+BLOCK_W] | ovf;
            end
            else
            begin
                sum[BASE +: BLOCK_W] = raw_sum[BASE +: BLOCK_W];
                blk_c[k]             = rc[BASE+BLOCK_W];
            end
        end
    end

    // All cells exact gives the full 33-bit sum, carry included
    always_comb
    begin
        if (&error_en)
            a_exact_sum: assert final ({blk_c[NBLK-1], sum} ==
                {1'b0, a} + {1'b0, b} + (XLEN+1)'(cin));
    end

endmodule

// ==== logic/barrel_shifter.sv ====
// --------------------------------------
// Logarithmic barrel shifter
// Left, logical right and arithmetic right
// --------------------------------------
`timescale 1ns/10ps

module barrel_shifter
#(
    parameter int WIDTH = 32
)
(
    input  logic [WIDTH-1:0]         value,
    input  logic [$clog2(WIDTH)-1:0] shamt,
    input  logic                     shift_right,
    input  logic                     arith,     // Sign fill, right shifts only
    output logic [WIDTH-1:0]         result
);
    localparam int SHAMT_W = $clog2(WIDTH);

    logic             fill;                 // Bit shifted in from the top
    logic [WIDTH-1:0] stage [SHAMT_W+1];    // Stage s shifts by 2**s

    assign fill     = arith & shift_right & value[WIDTH-1];
    assign stage[0] = value;

    for (genvar s = 0; s < SHAMT_W; s++)
    begin : g_stage
        localparam int STEP = 2 ** s;

        always_comb
        begin
            if (!shamt[s])
                stage[s+1] = stage[s];  // Bypass
            else if (shift_right)
                stage[s+1] = {{STEP{fill}}, stage[s][WIDTH-1:STEP]};
            else
                stage[s+1] = {stage[s][WIDTH-1-STEP:0], {STEP{1'b0}}};
        end
    end

    assign result = stage[SHAMT_W];

endmodule

// ==== logic/alu_decoder.sv ====
// --------------------------------------
// ALU decoder
// Opcode, funct3 and funct7 to ALU operation,
// operand source and illegal flag
// --------------------------------------
`timescale 1ns/10ps

module alu_decoder
(
    input  alu_cfg_pkg::alu_req_t req,
    output rv_isa_pkg::alu_op_e   alu_op,
    output logic                  use_imm,  // Second operand from immediate
    output logic                  illegal
);
    import rv_isa_pkg::*;

    // funct3 to operation for the plain F7_BASE encodings
    function automatic alu_op_e base_op(input funct3_e f3);
        alu_op_e op;
        case (f3)
            F3_ADD  : op = ALU_ADD;
            F3_SLL  : op = ALU_SLL;
            F3_SLT  : op = ALU_SLT;
            F3_SLTU : op = ALU_SLTU;
            F3_XOR  : op = ALU_XOR;
            F3_SR   : op = ALU_SRL;
            F3_OR   : op = ALU_OR;
            default : op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        alu_op  = ALU_NOP;  // Unsupported unless a branch below accepts it
        use_imm = 1'b0;
        illegal = 1'b1;
        case (req.opcode)
            OPC_OP:
            begin
                if (req.funct7 == F7_BASE)
                begin
                    alu_op  = base_op(req.funct3);
                    illegal = 1'b0;
                end
                else if (req.funct7 == F7_ALT && req.funct3 == F3_ADD)
                begin
                    alu_op  = ALU_SUB;
                    illegal = 1'b0;
                end
                else if (req.funct7 == F7_ALT && req.funct3 == F3_SR)
                begin
                    alu_op  = ALU_SRA;
                    illegal = 1'b0;
                end
            end
            OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                if (req.funct3 == F3_SR && req.funct7 == F7_ALT)
                begin
                    alu_op  = ALU_SRA;  // SRAI
                    illegal = 1'b0;
                end
                else if (!(req.funct3 inside {F3_SLL, F3_SR}) || req.funct7 == F7_BASE)
                begin
                    alu_op  = base_op(req.funct3);  // funct7 only matters for shifts
                    illegal = 1'b0;
                end
            end
            default: ;  // Other opcodes are not executed here
        endcase
    end

endmodule

// ==== logic/alu_cfg_pkg.sv ====
// --------------------------------------
// Execute ALU configuration
// Data widths and adder geometry
// Request, approximation control and response structs
// --------------------------------------
package alu_cfg_pkg;

    localparam int unsigned XLEN    = 32;   // Data width
    localparam int unsigned SHAMT_W = 5;    // Shift amount width
    localparam int unsigned APX_LEN = 8;    // Approximate low adder bits, multiple of 4
    localparam int unsigned BLOCK_W = 4;    // Carry-select block width

    typedef logic [XLEN-1:0] word_t;

    // Approximation control word, same layout as the core CSR
    typedef struct packed
    {
        logic [28:0] error_control;     // Per-bit error enables from bit 0 up
        logic [1:0]  circuit_select;    // No consumer, one adder only
        logic        approximate;       // 1 = approximate, 0 = exact
    } apx_ctrl_t;

    // One execute request, 113 bits
    typedef struct packed
    {
        rv_isa_pkg::opcode_e opcode;
        rv_isa_pkg::funct3_e funct3;
        logic [6:0]          funct7;    // Raw, may hold any value
        word_t               rs1;
        word_t               rs2;
        word_t               immediate;
    } alu_req_t;

    // Registered response, 33 bits
    typedef struct packed
    {
        word_t result;
        logic  illegal;     // Encoding outside OP / OP_IMM set
    } alu_rsp_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
// --------------------------------------
// RV32 encodings for the OP and OP_IMM groups
// Opcode, funct3 and funct7 enums
// Decoded ALU operation enum
// --------------------------------------
package rv_isa_pkg;

    // Major opcodes, only the integer ALU groups
    typedef enum logic [6:0]
    {
        OPC_OP_IMM = 7'b00_100_11,  // I-type ALU
        OPC_OP     = 7'b01_100_11   // R-type ALU
    } opcode_e;

    // Minor opcode, shared by both groups
    typedef enum logic [2:0]
    {
        F3_ADD  = 3'b000,   // ADD / SUB / ADDI
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,   // SRL / SRA, picked by funct7
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef enum logic [6:0]
    {
        F7_BASE = 7'b000_0000,
        F7_ALT  = 7'b010_0000   // SUB and SRA
    } funct7_e;

    // Decoded operation, NOP marks an illegal encoding
    typedef enum logic [3:0]
    {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_NOP
    } alu_op_e;

endpackage
